// ==== hw/bjp_pkg.sv ====
`default_nettype none

package bjp_pkg;

    // datapath and pc widths
    localparam int XLEN            = 32;
    localparam int INST_ADDR_WIDTH = 32;

    // rv32i major opcodes handled by this slice
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    // fence lives in misc-mem
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

    // branch funct3 encodings
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // sequential pc step, no compressed support
    localparam logic [XLEN-1:0] INST_STEP = 32'd4;

    // one instruction word, three field layouts
    typedef union packed {
        // b-type, immediate split around rs/funct3
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        // j-type, scrambled 20 bit offset
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
        // i-type, used by jalr and fence
        struct packed {
            logic [11:0] imm11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
    } inst_u;

endpackage

`default_nettype wire

// ==== hw/bjp_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module bjp_decode_stage (
    input  wire                                 clk_i,
    input  wire                                 rst_n_i,
    // incoming instruction beat
    input  wire                                 in_valid_i,
    output logic                                in_ready_o,
    input  wire  [bjp_pkg::INST_ADDR_WIDTH-1:0] pc_i,
    input  wire  [31:0]                         inst_i,
    input  wire  [bjp_pkg::XLEN-1:0]            rs1_val_i,
    input  wire  [bjp_pkg::XLEN-1:0]            rs2_val_i,
    input  wire                                 is_pred_branch_i,
    input  wire                                 int_assert_i,
    input  wire  [bjp_pkg::INST_ADDR_WIDTH-1:0] int_addr_i,
    // downstream can take our item
    input  wire                                 stage_ready_i,
    // registered decode towards the bru
    output logic                                dec_valid_o,
    output logic                                req_bjp_o,
    output logic                                op_beq_o,
    output logic                                op_bne_o,
    output logic                                op_blt_o,
    output logic                                op_bltu_o,
    output logic                                op_bge_o,
    output logic                                op_bgeu_o,
    output logic                                op_jump_o,
    output logic                                op_jalr_o,
    output logic [bjp_pkg::XLEN-1:0]            bjp_op1_o,
    output logic [bjp_pkg::XLEN-1:0]            bjp_op2_o,
    output logic [bjp_pkg::XLEN-1:0]            bjp_jump_op1_o,
    output logic [bjp_pkg::XLEN-1:0]            bjp_jump_op2_o,
    output logic                                is_pred_branch_o,
    output logic                                sys_op_fence_o,
    output logic                                int_assert_o,
    output logic [bjp_pkg::INST_ADDR_WIDTH-1:0] int_addr_o,
    output logic                                link_wen_o,
    output logic [bjp_pkg::XLEN-1:0]            link_data_o
);
    bjp_pkg::inst_u          inst;
    logic                    is_branch;
    logic                    is_jal;
    logic                    is_jalr;
    logic                    is_fence;
    logic [2:0]              f3;
    logic [bjp_pkg::XLEN-1:0] b_imm;
    logic [bjp_pkg::XLEN-1:0] j_imm;
    logic [bjp_pkg::XLEN-1:0] i_imm;
    logic [bjp_pkg::XLEN-1:0] jump_op2;
    logic                    accept;

    assign inst = inst_i;

    // opcode class read through each layout
    assign is_branch = (inst.b_fmt.opcode == bjp_pkg::OPC_BRANCH);
    assign is_jal    = (inst.j_fmt.opcode == bjp_pkg::OPC_JAL);
    assign is_jalr   = (inst.i_fmt.opcode == bjp_pkg::OPC_JALR);
    assign is_fence  = (inst.i_fmt.opcode == bjp_pkg::OPC_MISC_MEM);
    assign f3        = inst.b_fmt.funct3;

    // sign extended immediates with a zero lsb for b and j
    assign b_imm = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
                    inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
    assign j_imm = {{11{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
                    inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};
    assign i_imm = {{20{inst.i_fmt.imm11_0[11]}}, inst.i_fmt.imm11_0};

    // second adder operand where fence and others fall to pc+4
    assign jump_op2 = is_branch ? b_imm :
                      is_jal    ? j_imm :
                      is_jalr   ? i_imm : bjp_pkg::INST_STEP;

    // empty or our item leaves this cycle
    assign in_ready_o = ~dec_valid_o | stage_ready_i;
    assign accept     = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_o      <= 1'b0;
            req_bjp_o        <= 1'b0;
            op_beq_o         <= 1'b0;
            op_bne_o         <= 1'b0;
            op_blt_o         <= 1'b0;
            op_bltu_o        <= 1'b0;
            op_bge_o         <= 1'b0;
            op_bgeu_o        <= 1'b0;
            op_jump_o        <= 1'b0;
            op_jalr_o        <= 1'b0;
            is_pred_branch_o <= 1'b0;
            sys_op_fence_o   <= 1'b0;
            int_assert_o     <= 1'b0;
            link_wen_o       <= 1'b0;
        end else begin
            if (in_ready_o) begin
                dec_valid_o <= in_valid_i;
            end
            if (accept) begin
                req_bjp_o <= is_branch | is_jal | is_jalr;
                op_beq_o  <= is_branch & (f3 == bjp_pkg::F3_BEQ);
                op_bne_o  <= is_branch & (f3 == bjp_pkg::F3_BNE);
                op_blt_o  <= is_branch & (f3 == bjp_pkg::F3_BLT);
                op_bltu_o <= is_branch & (f3 == bjp_pkg::F3_BLTU);
                op_bge_o  <= is_branch & (f3 == bjp_pkg::F3_BGE);
                op_bgeu_o <= is_branch & (f3 == bjp_pkg::F3_BGEU);
                // jump covers both jal and jalr
                op_jump_o <= is_jal | is_jalr;
                op_jalr_o <= is_jalr;
                // fetch only predicts branch and jal
                is_pred_branch_o <= is_pred_branch_i & (is_branch | is_jal);
                sys_op_fence_o   <= is_fence;
                int_assert_o     <= int_assert_i;
                link_wen_o       <= is_jal | is_jalr;
            end
        end
    end

    // operands and addresses
    always_ff @(posedge clk_i) begin
        if (accept) begin
            bjp_op1_o      <= rs1_val_i;
            bjp_op2_o      <= rs2_val_i;
            // jalr is register relative and the rest pc relative
            bjp_jump_op1_o <= is_jalr ? rs1_val_i : pc_i;
            bjp_jump_op2_o <= jump_op2;
            int_addr_o     <= int_addr_i;
            link_data_o    <= pc_i + bjp_pkg::INST_STEP;
        end
    end

    // a refused beat stays put at the source
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (in_valid_i && !in_ready_o) |=> (in_valid_i && $stable(pc_i) && $stable(inst_i) &&
            $stable(rs1_val_i) && $stable(rs2_val_i) && $stable(is_pred_branch_i) &&
            $stable(int_assert_i) && $stable(int_addr_i)))
        else $error("input beat changed before it transferred");

endmodule

`default_nettype wire

// ==== hw/exu_bru.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_bru (
    // only samples the assertions
    input  wire                                 clk_i,
    input  wire                                 req_bjp_i,
    input  wire                                 op_beq_i,
    input  wire                                 op_bne_i,
    input  wire                                 op_blt_i,
    input  wire                                 op_bltu_i,
    input  wire                                 op_bge_i,
    input  wire                                 op_bgeu_i,
    // jal or jalr
    input  wire                                 op_jump_i,
    input  wire                                 op_jalr_i,
    // compare operands
    input  wire  [bjp_pkg::XLEN-1:0]            bjp_op1_i,
    input  wire  [bjp_pkg::XLEN-1:0]            bjp_op2_i,
    // target adder operands
    input  wire  [bjp_pkg::XLEN-1:0]            bjp_jump_op1_i,
    input  wire  [bjp_pkg::XLEN-1:0]            bjp_jump_op2_i,
    // fetch already steered to the target
    input  wire                                 is_pred_branch_i,
    input  wire                                 sys_op_fence_i,
    input  wire                                 int_assert_i,
    input  wire  [bjp_pkg::INST_ADDR_WIDTH-1:0] int_addr_i,
    output logic                                jump_flag_o,
    output logic [bjp_pkg::INST_ADDR_WIDTH-1:0] jump_addr_o
);
    logic                     op1_eq_op2;
    logic                     op1_ge_op2_signed;
    logic                     op1_ge_op2_unsigned;
    logic                     branch_cond;
    logic                     pred_rollback;
    logic [bjp_pkg::XLEN-1:0] adder_op2;
    logic [bjp_pkg::XLEN-1:0] adder_result;

    // one equality and two magnitude compares serve all six branches
    assign op1_eq_op2          = (bjp_op1_i == bjp_op2_i);
    assign op1_ge_op2_signed   = $signed(bjp_op1_i) >= $signed(bjp_op2_i);
    assign op1_ge_op2_unsigned = bjp_op1_i >= bjp_op2_i;

    // taken condition where jumps are always taken
    assign branch_cond = req_bjp_i & (
        (op_beq_i  &  op1_eq_op2) |
        (op_bne_i  & ~op1_eq_op2) |
        (op_blt_i  & ~op1_ge_op2_signed) |
        (op_bge_i  &  op1_ge_op2_signed) |
        (op_bltu_i & ~op1_ge_op2_unsigned) |
        (op_bgeu_i &  op1_ge_op2_unsigned) |
        op_jump_i |
        op_jalr_i
    );

    // predicted taken but falls through
    assign pred_rollback = is_pred_branch_i & req_bjp_i & ~branch_cond;

    // shared adder and rollback returns to the fall-through pc
    assign adder_op2    = pred_rollback ? bjp_pkg::INST_STEP : bjp_jump_op2_i;
    assign adder_result = bjp_jump_op1_i + adder_op2;

    // redirect unless fetch got it right already
    assign jump_flag_o = int_assert_i | (branch_cond & ~is_pred_branch_i) |
                         sys_op_fence_i | pred_rollback;

    // interrupt wins and a jalr target is halfword aligned
    assign jump_addr_o = int_assert_i ? int_addr_i :
        {adder_result[bjp_pkg::INST_ADDR_WIDTH-1:1], adder_result[0] & ~op_jalr_i};

    // fetch only predicts branch and jal
    assert property (@(posedge clk_i) is_pred_branch_i |-> (req_bjp_i && !op_jalr_i))
        else $error("bru got a prediction for an instruction that cannot be predicted");

    // decode hands over at most one operation
    assert property (@(posedge clk_i) $onehot0({op_beq_i, op_bne_i, op_blt_i, op_bltu_i,
        op_bge_i, op_bgeu_i, op_jump_i, sys_op_fence_i}))
        else $error("bru got more than one operation at once");

endmodule

`default_nettype wire

// ==== hw/bjp_result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module bjp_result_stage (
    input  wire                                 clk_i,
    input  wire                                 rst_n_i,
    // decode register holds an item
    input  wire                                 dec_valid_i,
    // resolved redirect from the bru
    input  wire                                 jump_flag_i,
    input  wire  [bjp_pkg::INST_ADDR_WIDTH-1:0] jump_addr_i,
    // link write, pc+4
    input  wire                                 link_wen_i,
    input  wire  [bjp_pkg::XLEN-1:0]            link_data_i,
    output logic                                stage_ready_o,
    // outgoing stream
    output logic                                out_valid_o,
    input  wire                                 out_ready_i,
    output logic                                jump_flag_o,
    output logic [bjp_pkg::INST_ADDR_WIDTH-1:0] jump_addr_o,
    output logic                                link_wen_o,
    output logic [bjp_pkg::XLEN-1:0]            link_data_o
);
    logic jump_flag_q;
    logic link_wen_q;
    logic capture;

    // free, or current item leaves this edge
    assign stage_ready_o = ~out_valid_o | out_ready_i;
    assign capture       = dec_valid_i & stage_ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else if (stage_ready_o) begin
            out_valid_o <= dec_valid_i;
        end
    end

    // result holding register, frozen while stalled
    always_ff @(posedge clk_i) begin
        if (capture) begin
            jump_flag_q <= jump_flag_i;
            jump_addr_o <= jump_addr_i;
            link_wen_q  <= link_wen_i;
            link_data_o <= link_data_i;
        end
    end

    // strobes only mean something with a valid item
    assign jump_flag_o = out_valid_o & jump_flag_q;
    assign link_wen_o  = out_valid_o & link_wen_q;

    // stalled output must not move
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(jump_flag_o) &&
            $stable(jump_addr_o) && $stable(link_wen_o) && $stable(link_data_o)))
        else $error("result stage output changed while stalled");

endmodule

`default_nettype wire

// ==== hw/bjp_exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bjp_exu_top (
    input  wire                                 clk_i,
    input  wire                                 rst_n_i,
    // instruction stream in
    input  wire                                 in_valid_i,
    output logic                                in_ready_o,
    input  wire  [bjp_pkg::INST_ADDR_WIDTH-1:0] pc_i,
    input  wire  [31:0]                         inst_i,
    input  wire  [bjp_pkg::XLEN-1:0]            rs1_val_i,
    input  wire  [bjp_pkg::XLEN-1:0]            rs2_val_i,
    input  wire                                 is_pred_branch_i,
    input  wire                                 int_assert_i,
    input  wire  [bjp_pkg::INST_ADDR_WIDTH-1:0] int_addr_i,
    // resolution stream out
    output logic                                out_valid_o,
    input  wire                                 out_ready_i,
    output logic                                jump_flag_o,
    output logic [bjp_pkg::INST_ADDR_WIDTH-1:0] jump_addr_o,
    output logic                                link_wen_o,
    output logic [bjp_pkg::XLEN-1:0]            link_data_o
);
    // decode register to bru
    logic                              dec_valid;
    logic                              req_bjp;
    logic                              op_beq;
    logic                              op_bne;
    logic                              op_blt;
    logic                              op_bltu;
    logic                              op_bge;
    logic                              op_bgeu;
    logic                              op_jump;
    logic                              op_jalr;
    logic [bjp_pkg::XLEN-1:0]            bjp_op1;
    logic [bjp_pkg::XLEN-1:0]            bjp_op2;
    logic [bjp_pkg::XLEN-1:0]            bjp_jump_op1;
    logic [bjp_pkg::XLEN-1:0]            bjp_jump_op2;
    logic                              is_pred_branch;
    logic                              sys_op_fence;
    logic                              int_assert;
    logic [bjp_pkg::INST_ADDR_WIDTH-1:0] int_addr;
    // decode register straight to result stage
    logic                              link_wen;
    logic [bjp_pkg::XLEN-1:0]            link_data;
    // bru to result stage
    logic                              jump_flag;
    logic [bjp_pkg::INST_ADDR_WIDTH-1:0] jump_addr;
    // back-pressure into decode
    logic                              stage_ready;

    bjp_decode_stage u_decode (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .in_valid_i       (in_valid_i),
        .in_ready_o       (in_ready_o),
        .pc_i             (pc_i),
        .inst_i           (inst_i),
        .rs1_val_i        (rs1_val_i),
        .rs2_val_i        (rs2_val_i),
        .is_pred_branch_i (is_pred_branch_i),
        .int_assert_i     (int_assert_i),
        .int_addr_i       (int_addr_i),
        .stage_ready_i    (stage_ready),
        .dec_valid_o      (dec_valid),
        .req_bjp_o        (req_bjp),
        .op_beq_o         (op_beq),
        .op_bne_o         (op_bne),
        .op_blt_o         (op_blt),
        .op_bltu_o        (op_bltu),
        .op_bge_o         (op_bge),
        .op_bgeu_o        (op_bgeu),
        .op_jump_o        (op_jump),
        .op_jalr_o        (op_jalr),
        .bjp_op1_o        (bjp_op1),
        .bjp_op2_o        (bjp_op2),
        .bjp_jump_op1_o   (bjp_jump_op1),
        .bjp_jump_op2_o   (bjp_jump_op2),
        .is_pred_branch_o (is_pred_branch),
        .sys_op_fence_o   (sys_op_fence),
        .int_assert_o     (int_assert),
        .int_addr_o       (int_addr),
        .link_wen_o       (link_wen),
        .link_data_o      (link_data)
    );

    // purely combinational between the two registers
    exu_bru u_bru (
        .clk_i            (clk_i),
        .req_bjp_i        (req_bjp),
        .op_beq_i         (op_beq),
        .op_bne_i         (op_bne),
        .op_blt_i         (op_blt),
        .op_bltu_i        (op_bltu),
        .op_bge_i         (op_bge),
        .op_bgeu_i        (op_bgeu),
        .op_jump_i        (op_jump),
        .op_jalr_i        (op_jalr),
        .bjp_op1_i        (bjp_op1),
        .bjp_op2_i        (bjp_op2),
        .bjp_jump_op1_i   (bjp_jump_op1),
        .bjp_jump_op2_i   (bjp_jump_op2),
        .is_pred_branch_i (is_pred_branch),
        .sys_op_fence_i   (sys_op_fence),
        .int_assert_i     (int_assert),
        .int_addr_i       (int_addr),
        .jump_flag_o      (jump_flag),
        .jump_addr_o      (jump_addr)
    );

    bjp_result_stage u_result (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .dec_valid_i   (dec_valid),
        .jump_flag_i   (jump_flag),
        .jump_addr_i   (jump_addr),
        .link_wen_i    (link_wen),
        .link_data_i   (link_data),
        .stage_ready_o (stage_ready),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .jump_flag_o   (jump_flag_o),
        .jump_addr_o   (jump_addr_o),
        .link_wen_o    (link_wen_o),
        .link_data_o   (link_data_o)
    );

endmodule

`default_nettype wire

// ==== dv/bjp_ref_model.svh ====
`ifndef BJP_REF_MODEL_SVH
`define BJP_REF_MODEL_SVH

// one step of the 32 bit lcg
function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// expected result of one accepted beat, straight from the isa rules
function automatic void resolve_beat(
    input  logic [31:0] pc,
    input  logic [31:0] inst_word,
    input  logic [31:0] rs1,
    input  logic [31:0] rs2,
    input  logic        pred_in,
    input  logic        irq,
    input  logic [31:0] irq_addr,
    output logic        exp_flag,
    output logic [31:0] exp_addr,
    output logic        exp_wen,
    output logic [31:0] exp_data
);
    bjp_pkg::inst_u     iw;
    logic               is_br;
    logic               is_jal;
    logic               is_jalr;
    logic               is_fence;
    logic               pred;
    logic               cond;
    logic               rollback;
    logic signed [12:0] b_off;
    logic signed [20:0] j_off;
    logic signed [11:0] i_off;
    logic [31:0]        base;
    logic [31:0]        offset;
    logic [31:0]        target;

    iw       = inst_word;
    is_br    = (iw.b_fmt.opcode == bjp_pkg::OPC_BRANCH);
    is_jal   = (iw.j_fmt.opcode == bjp_pkg::OPC_JAL);
    is_jalr  = (iw.i_fmt.opcode == bjp_pkg::OPC_JALR);
    is_fence = (iw.i_fmt.opcode == bjp_pkg::OPC_MISC_MEM);

    // offsets as signed byte distances
    b_off = {iw.b_fmt.imm12, iw.b_fmt.imm11, iw.b_fmt.imm10_5, iw.b_fmt.imm4_1, 1'b0};
    j_off = {iw.j_fmt.imm20, iw.j_fmt.imm19_12, iw.j_fmt.imm11, iw.j_fmt.imm10_1, 1'b0};
    i_off = iw.i_fmt.imm11_0;

    cond = 1'b0;
    if (is_br) begin
        case (iw.b_fmt.funct3)
            bjp_pkg::F3_BEQ:  cond = (rs1 == rs2);
            bjp_pkg::F3_BNE:  cond = (rs1 != rs2);
            bjp_pkg::F3_BLT:  cond = ($signed(rs1) < $signed(rs2));
            bjp_pkg::F3_BGE:  cond = ($signed(rs1) >= $signed(rs2));
            bjp_pkg::F3_BLTU: cond = (rs1 < rs2);
            bjp_pkg::F3_BGEU: cond = (rs1 >= rs2);
            default:          cond = 1'b0;
        endcase
    end
    // unconditional jumps
    if (is_jal || is_jalr) begin
        cond = 1'b1;
    end

    // fetch prediction only exists for branch and jal
    pred     = pred_in & (is_br | is_jal);
    rollback = pred & ~cond;

    base = is_jalr ? rs1 : pc;
    if (is_br) begin
        offset = 32'(b_off);
    end else if (is_jal) begin
        offset = 32'(j_off);
    end else if (is_jalr) begin
        offset = 32'(i_off);
    end else begin
        offset = bjp_pkg::INST_STEP;
    end
    target = rollback ? (pc + bjp_pkg::INST_STEP) : (base + offset);
    if (is_jalr) begin
        target[0] = 1'b0;
    end

    exp_flag = irq | (cond & ~pred) | is_fence | rollback;
    exp_addr = irq ? irq_addr : target;
    exp_wen  = is_jal | is_jalr;
    exp_data = pc + bjp_pkg::INST_STEP;
endfunction

`endif

// ==== dv/tb_bjp_exu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_bjp_exu;

    localparam int NUM_BEATS  = 2000;
    localparam int CLK_PERIOD = 20;
    // 20 cycles per beat is far above the real rate
    localparam longint TIMEOUT_NS = longint'(NUM_BEATS) * 20 * CLK_PERIOD + 2000;
    // plain register alu op, no redirect expected
    localparam logic [6:0] OPC_ALU = 7'b0110011;

    typedef struct packed {
        logic        jump_flag;
        logic [31:0] jump_addr;
        logic        link_wen;
        logic [31:0] link_data;
        logic [31:0] acc_cycle;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic        is_pred_branch;
    logic        int_assert;
    logic [31:0] int_addr;
    logic        out_valid;
    logic        out_ready;
    logic        jump_flag;
    logic [31:0] jump_addr;
    logic        link_wen;
    logic [31:0] link_data;

    expect_t     exp_q[$];
    logic [31:0] rnd_state = 32'h93f9;
    int          mismatch_cnt = 0;
    int          fail_cnt = 0;
    int          sent_cnt = 0;
    int          recv_cnt = 0;
    int          cycle = 0;
    int          last_stall_cycle = 0;

    `include "bjp_ref_model.svh"

    bjp_exu_top dut (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .in_valid_i       (in_valid),
        .in_ready_o       (in_ready),
        .pc_i             (pc),
        .inst_i           (inst),
        .rs1_val_i        (rs1_val),
        .rs2_val_i        (rs2_val),
        .is_pred_branch_i (is_pred_branch),
        .int_assert_i     (int_assert),
        .int_addr_i       (int_addr),
        .out_valid_o      (out_valid),
        .out_ready_i      (out_ready),
        .jump_flag_o      (jump_flag),
        .jump_addr_o      (jump_addr),
        .link_wen_o       (link_wen),
        .link_data_o      (link_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        rnd_state = lcg_step(rnd_state);
        return rnd_state;
    endfunction

    // upper halves only, low lcg bits cycle too fast
    function automatic logic [31:0] rand_word();
        logic [31:0] a;
        logic [31:0] b;
        a = next_rand();
        b = next_rand();
        return {a[31:16], b[31:16]};
    endfunction

    // sign edges show up often
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = next_rand();
        if (r[31:30] != 2'b00) begin
            return rand_word();
        end
        case (r[23:21] % 3'd6)
            3'd0:    return 32'h0000_0000;
            3'd1:    return 32'h0000_0001;
            3'd2:    return 32'h7fff_ffff;
            3'd3:    return 32'h8000_0000;
            3'd4:    return 32'hffff_ffff;
            default: return 32'h8000_0001;
        endcase
    endfunction

    // new beat or idle, about one in five idle
    task automatic drive_next_beat();
        logic [31:0]    r;
        bjp_pkg::inst_u word;
        int             sel;
        r = next_rand();
        if (sent_cnt >= NUM_BEATS || r[31:24] < 8'd51) begin
            in_valid = 1'b0;
        end else begin
            word = rand_word();
            sel  = int'(next_rand() >> 16) % 10;
            case (sel)
                0: word.b_fmt.funct3 = bjp_pkg::F3_BEQ;
                1: word.b_fmt.funct3 = bjp_pkg::F3_BNE;
                2: word.b_fmt.funct3 = bjp_pkg::F3_BLT;
                3: word.b_fmt.funct3 = bjp_pkg::F3_BGE;
                4: word.b_fmt.funct3 = bjp_pkg::F3_BLTU;
                5: word.b_fmt.funct3 = bjp_pkg::F3_BGEU;
                default: word.i_fmt.funct3 = 3'b000;
            endcase
            if (sel < 6) begin
                word.b_fmt.opcode = bjp_pkg::OPC_BRANCH;
            end else if (sel == 6) begin
                word.j_fmt.opcode = bjp_pkg::OPC_JAL;
            end else if (sel == 7) begin
                word.i_fmt.opcode = bjp_pkg::OPC_JALR;
            end else if (sel == 8) begin
                word.i_fmt.opcode = bjp_pkg::OPC_MISC_MEM;
            end else begin
                word.i_fmt.opcode = OPC_ALU;
            end
            inst    = word;
            pc      = rand_word() & 32'hffff_fffc;
            rs1_val = pick_operand();
            r       = next_rand();
            // roughly a quarter with equal operands
            rs2_val = (r[31:30] == 2'b00) ? rs1_val : pick_operand();
            r       = next_rand();
            is_pred_branch = (r[31:24] < 8'd77);
            int_assert     = (r[23:20] == 4'h0);
            int_addr       = rand_word() & 32'hffff_fffc;
            in_valid       = 1'b1;
            sent_cnt++;
        end
    endtask

    task automatic record_accept();
        expect_t     e;
        logic        f;
        logic [31:0] a;
        logic        w;
        logic [31:0] d;
        resolve_beat(pc, inst, rs1_val, rs2_val, is_pred_branch, int_assert, int_addr,
                     f, a, w, d);
        e.jump_flag = f;
        e.jump_addr = a;
        e.link_wen  = w;
        e.link_data = d;
        e.acc_cycle = cycle;
        exp_q.push_back(e);
    endtask

    task automatic check_output(input expect_t e);
        int lat;
        assert (jump_flag === e.jump_flag) else begin
            $display("mismatch at %0t: jump_flag_o got %0b expected %0b",
                     $time, jump_flag, e.jump_flag);
            mismatch_cnt++;
        end
        // address only defined with a redirect
        if (e.jump_flag) begin
            assert (jump_addr === e.jump_addr) else begin
                $display("mismatch at %0t: jump_addr_o got 0x%08h expected 0x%08h",
                         $time, jump_addr, e.jump_addr);
                mismatch_cnt++;
            end
        end
        assert (link_wen === e.link_wen) else begin
            $display("mismatch at %0t: link_wen_o got %0b expected %0b",
                     $time, link_wen, e.link_wen);
            mismatch_cnt++;
        end
        if (e.link_wen) begin
            assert (link_data === e.link_data) else begin
                $display("mismatch at %0t: link_data_o got 0x%08h expected 0x%08h",
                         $time, link_data, e.link_data);
                mismatch_cnt++;
            end
        end
        lat = cycle - int'(e.acc_cycle);
        assert (lat >= 2) else begin
            $display("at %0t a result left only %0d cycles after its beat was accepted",
                     $time, lat);
            fail_cnt++;
        end
        // no stall since the beat entered, so the pipe must be tight
        if (last_stall_cycle <= int'(e.acc_cycle)) begin
            assert (lat == 2) else begin
                $display("at %0t a result took %0d cycles with the output never stalled",
                         $time, lat);
                fail_cnt++;
            end
        end
    endtask

    task automatic check_reset_state();
        assert (out_valid === 1'b0) else begin
            $display("mismatch at %0t: out_valid_o got %0b expected 0", $time, out_valid);
            mismatch_cnt++;
        end
        assert (jump_flag === 1'b0) else begin
            $display("mismatch at %0t: jump_flag_o got %0b expected 0", $time, jump_flag);
            mismatch_cnt++;
        end
        assert (link_wen === 1'b0) else begin
            $display("mismatch at %0t: link_wen_o got %0b expected 0", $time, link_wen);
            mismatch_cnt++;
        end
        assert (in_ready === 1'b1) else begin
            $display("mismatch at %0t: in_ready_o got %0b expected 1", $time, in_ready);
            mismatch_cnt++;
        end
    endtask

    initial begin : main
        logic in_fire;
        logic out_fire;
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        pc             = '0;
        inst           = '0;
        rs1_val        = '0;
        rs2_val        = '0;
        is_pred_branch = 1'b0;
        int_assert     = 1'b0;
        int_addr       = '0;
        out_ready      = 1'b1;
        in_fire        = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        #2;
        check_reset_state();
        while (recv_cnt < NUM_BEATS) begin
            @(negedge clk);
            cycle++;
            // a pending beat stays put until it transfers
            if (!in_valid || in_fire) begin
                drive_next_beat();
            end
            out_ready = (next_rand() % 100) >= 30;
            // handshakes sampled mid low phase
            #2;
            in_fire  = in_valid & in_ready;
            out_fire = out_valid & out_ready;
            if (!out_ready) begin
                last_stall_cycle = cycle;
            end
            if (in_fire) begin
                record_accept();
            end
            if (out_fire) begin
                recv_cnt++;
                assert (exp_q.size() > 0) else begin
                    $display("at %0t an output beat arrived with no accepted input", $time);
                    fail_cnt++;
                end
                if (exp_q.size() > 0) begin
                    check_output(exp_q.pop_front());
                end
            end
        end
        // drained pipe must stay quiet
        in_valid  = 1'b0;
        out_ready = 1'b1;
        repeat (4) begin
            @(negedge clk);
            #2;
            assert (out_valid === 1'b0) else begin
                $display("at %0t an extra output beat appeared after the last one", $time);
                fail_cnt++;
            end
        end
        assert (exp_q.size() == 0) else begin
            $display("%0d accepted beats never produced a result", exp_q.size());
            fail_cnt++;
        end
        $display("checks done: %0d mismatches, %0d other failures over %0d beats",
                 mismatch_cnt, fail_cnt, recv_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("watchdog expired with %0d of %0d results received", recv_cnt, NUM_BEATS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+dv
hw/bjp_pkg.sv
hw/bjp_decode_stage.sv
hw/exu_bru.sv
hw/bjp_result_stage.sv
hw/bjp_exu_top.sv
dv/tb_bjp_exu.sv

// ==== Makefile ====
# Verilator build and run for the branch resolution testbench

TOP       ?= tb_bjp_exu
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard dv/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides the result, a crash with no message fails too
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q -e "TESTBENCH FAILED" -e "%Error" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
